/* Bender.yml */
package:
  name: aexec

sources:
  - files:
      - common/aluPkg.sv
      - aexec/aluControl.sv
      - aexec/aluDatapath.sv
      - source/creditCounter.sv
      - source/pipeStage.sv
      - source/aExecUnit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/aExecTb.sv

/* aexec/aluControl.sv */
`timescale 1ns/10ps
`default_nettype none
// Issue-cycle decode and operand select, purely combinational
// opLui forces operand b to the shifted immediate whatever useImm says
// Shifts act on operand b, as in MIPS sll/srl/sra

module aluControl (
    input  logic                          issueValid,
    input  aluPkg::aluOp_e                op,
    input  logic [aluPkg::DATA_WIDTH-1:0] srcS,
    input  logic [aluPkg::DATA_WIDTH-1:0] srcT,
    input  logic [aluPkg::IMM_WIDTH-1:0]  imm16,
    input  logic                          useImm,
    input  logic                          immSigned,
    input  logic [aluPkg::SHAMT_WIDTH-1:0] shamt,
    input  logic                          shiftVariable,
    input  logic                          stall,
    output logic                          accept,
    output aluPkg::aluOperands_s          operands
);
    import aluPkg::*;

    logic                   isLui;
    logic [DATA_WIDTH-1:0]  immExt;
    logic [DATA_WIDTH-1:0]  opA;
    logic [DATA_WIDTH-1:0]  opB;
    logic [SHAMT_WIDTH-1:0] shiftAmt;
    aluCtrl_s               ctrl;

    // Single point where issue is qualified
    assign accept = issueValid & ~stall;

    assign isLui = (op == opLui);

    // Immediate forms: upper half, sign or zero extended
    always_comb begin
        if (isLui) begin
            immExt = {imm16, {(DATA_WIDTH-IMM_WIDTH){1'b0}}};
        end else if (immSigned) begin
            immExt = {{(DATA_WIDTH-IMM_WIDTH){imm16[IMM_WIDTH-1]}}, imm16};
        end else begin
            immExt = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm16};
        end
    end

    // Lui is an OR against zero
    assign opA = isLui ? '0 : srcS;
    assign opB = (useImm | isLui) ? immExt : srcT;

    // Variable shifts take the amount from register s
    assign shiftAmt = shiftVariable ? srcS[SHAMT_WIDTH-1:0] : shamt;

    // Op decode into the datapath control word
    always_comb begin
        ctrl         = '0;
        ctrl.unitSel = UNIT_ADD;
        case (op)
            opAdd: ctrl.ovflEnable = 1'b1;
            opSub: begin
                ctrl.carryIn    = 1'b1;
                ctrl.invertB    = 1'b1;
                ctrl.ovflEnable = 1'b1;
            end
            opSubu: begin
                ctrl.carryIn = 1'b1;
                ctrl.invertB = 1'b1;
            end
            opSlt, opSltu: begin
                ctrl.carryIn   = 1'b1;
                ctrl.invertB   = 1'b1;
                ctrl.unitSel   = UNIT_SET;
                ctrl.setSigned = (op == opSlt);
            end
            opAnd: begin
                ctrl.unitSel = UNIT_LOGIC;
                ctrl.logicFn = LOGIC_AND;
            end
            opOr, opLui: begin
                ctrl.unitSel = UNIT_LOGIC;
                ctrl.logicFn = LOGIC_OR;
            end
            opXor: begin
                ctrl.unitSel = UNIT_LOGIC;
                ctrl.logicFn = LOGIC_XOR;
            end
            opNor: begin
                ctrl.unitSel = UNIT_LOGIC;
                ctrl.logicFn = LOGIC_NOR;
            end
            opSll: ctrl.unitSel = UNIT_SHIFT;
            opSrl, opSra: begin
                ctrl.unitSel    = UNIT_SHIFT;
                ctrl.shiftRight = 1'b1;
                ctrl.shiftArith = (op == opSra);
            end
            // opAddu keeps the plain add defaults
            default: ;
        endcase
    end

    assign operands = '{a: opA, b: opB, shamt: shiftAmt, ctrl: ctrl};

    // Upstream decoder must never present an unlisted op
    always_comb begin
        if (issueValid) begin
            assert final (op inside {opAdd, opAddu, opSub, opSubu, opSlt, opSltu,
                                     opAnd, opOr, opXor, opNor, opSll, opSrl,
                                     opSra, opLui})
                else $error("illegal ALU op %0d on issue", op);
        end
    end

endmodule

`default_nettype wire

/* aexec/aluDatapath.sv */
`timescale 1ns/10ps
`default_nettype none
// Execute stage arithmetic, combinational from operands to result
// Overflow is reported only when the control word enables it
// Set results come from the shared adder, so b must already be inverted

module aluDatapath (
    input  aluPkg::aluOperands_s operands,
    output aluPkg::aluResult_s   result
);
    import aluPkg::*;

    localparam int MSB = DATA_WIDTH - 1;

    aluCtrl_s              ctrl;
    logic [DATA_WIDTH-1:0] opA;
    logic [DATA_WIDTH-1:0] opB;
    logic [DATA_WIDTH-1:0] bEff;
    logic [DATA_WIDTH-1:0] sum;
    logic                  carryOut;
    logic                  ovflRaw;
    logic                  setBit;
    logic [DATA_WIDTH-1:0] logicRes;
    logic [DATA_WIDTH:0]   sraIn;
    logic [DATA_WIDTH:0]   shiftWide;
    logic [DATA_WIDTH-1:0] shiftRes;
    logic [DATA_WIDTH-1:0] aluValue;

    assign ctrl = operands.ctrl;
    assign opA  = operands.a;
    assign opB  = operands.b;

    // Single adder for add, sub and compare
    assign bEff = ctrl.invertB ? ~opB : opB;
    assign {carryOut, sum} = {1'b0, opA} + {1'b0, bEff}
                           + {{DATA_WIDTH{1'b0}}, ctrl.carryIn};

    // Same input signs, different sum sign
    assign ovflRaw = (opA[MSB] == bEff[MSB]) & (sum[MSB] != opA[MSB]);

    // Signed less-than corrects the sign for overflow
    // unsigned less-than is a borrow out
    assign setBit = ctrl.setSigned ? (sum[MSB] ^ ovflRaw) : ~carryOut;

    // Logic unit
    always_comb begin
        case (ctrl.logicFn)
            LOGIC_AND: logicRes = opA & opB;
            LOGIC_OR:  logicRes = opA | opB;
            LOGIC_XOR: logicRes = opA ^ opB;
            default:   logicRes = ~(opA | opB);
        endcase
    end

    // Barrel shifter on operand b
    // Extra top bit carries the fill value for right shifts
    assign sraIn     = {ctrl.shiftArith & opB[MSB], opB};
    assign shiftWide = $signed(sraIn) >>> operands.shamt;
    assign shiftRes  = ctrl.shiftRight ? shiftWide[DATA_WIDTH-1:0]
                                       : (opB << operands.shamt);

    // Output select
    always_comb begin
        case (ctrl.unitSel)
            UNIT_ADD:   aluValue = sum;
            UNIT_LOGIC: aluValue = logicRes;
            UNIT_SET:   aluValue = {{(DATA_WIDTH-1){1'b0}}, setBit};
            default:    aluValue = shiftRes;
        endcase
    end

    assign result = '{value: aluValue, overflow: ovflRaw & ctrl.ovflEnable};

endmodule

`default_nettype wire

/* common/aluPkg.sv */
`default_nettype none
// Shared types and constants for the A-side execute unit
// Enum encodings are fixed; opLui must stay the highest legal value
// Control word layout is internal to the unit and may change

package aluPkg;

    // Datapath widths
    localparam int DATA_WIDTH  = 32;
    localparam int IMM_WIDTH   = 16;
    localparam int SHAMT_WIDTH = 5;

    // Write buffer slots downstream, also the counter reset value
    localparam int RESULT_CREDITS = 4;
    localparam int CREDIT_WIDTH   = 3;

    // Result unit select
    localparam logic [1:0] UNIT_ADD   = 2'd0;
    localparam logic [1:0] UNIT_LOGIC = 2'd1;
    localparam logic [1:0] UNIT_SET   = 2'd2;
    localparam logic [1:0] UNIT_SHIFT = 2'd3;

    // Logic unit functions
    localparam logic [1:0] LOGIC_AND = 2'd0;
    localparam logic [1:0] LOGIC_OR  = 2'd1;
    localparam logic [1:0] LOGIC_XOR = 2'd2;
    localparam logic [1:0] LOGIC_NOR = 2'd3;

    // Decoded ALU operations
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opAddu = 4'd1,
        opSub  = 4'd2,
        opSubu = 4'd3,
        opSlt  = 4'd4,
        opSltu = 4'd5,
        opAnd  = 4'd6,
        opOr   = 4'd7,
        opXor  = 4'd8,
        opNor  = 4'd9,
        opSll  = 4'd10,
        opSrl  = 4'd11,
        opSra  = 4'd12,
        opLui  = 4'd13
    } aluOp_e;

    // Control word carried alongside the operands
    typedef struct packed {
        logic       carryIn;     // Subtract and set ops
        logic       invertB;
        logic [1:0] unitSel;
        logic [1:0] logicFn;
        logic       setSigned;
        logic       ovflEnable;  // opAdd and opSub only
        logic       shiftRight;
        logic       shiftArith;
    } aluCtrl_s;

    // Execute stage payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0]  a;
        logic [DATA_WIDTH-1:0]  b;
        logic [SHAMT_WIDTH-1:0] shamt;
        aluCtrl_s               ctrl;
    } aluOperands_s;

    // Result stage payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0] value;
        logic                  overflow;
    } aluResult_s;

endpackage

`default_nettype wire

/* dv/aExecRef.svh */
// Reference model for the execute unit, included inside the testbench module
// Expects aluPkg to be imported by the including scope
// Shifts act on operand b; opLui ignores srcS and useImm

`ifndef AEXEC_REF_SVH
`define AEXEC_REF_SVH

// Immediate as operand b: upper half for lui, else sign or zero extended
function automatic logic [DATA_WIDTH-1:0] immOperand(input aluOp_e op,
                                                     input logic [IMM_WIDTH-1:0] imm16,
                                                     input logic immSigned);
    if (op == opLui) begin
        return {imm16, 16'h0000};
    end
    if (immSigned) begin
        return {{16{imm16[IMM_WIDTH-1]}}, imm16};
    end
    return {16'h0000, imm16};
endfunction

// Expected result and overflow for one issue
function automatic aluResult_s refAlu(input aluOp_e op,
                                      input logic [DATA_WIDTH-1:0] srcS,
                                      input logic [DATA_WIDTH-1:0] srcT,
                                      input logic [IMM_WIDTH-1:0] imm16,
                                      input logic useImm,
                                      input logic immSigned,
                                      input logic [SHAMT_WIDTH-1:0] shamt,
                                      input logic shiftVariable);
    logic [DATA_WIDTH-1:0]  b;
    logic [DATA_WIDTH-1:0]  r;
    logic [SHAMT_WIDTH-1:0] sh;
    logic                   ovf;
    b   = (useImm || op == opLui) ? immOperand(op, imm16, immSigned) : srcT;
    sh  = shiftVariable ? srcS[SHAMT_WIDTH-1:0] : shamt;
    ovf = 1'b0;
    case (op)
        opAdd, opAddu: begin
            r = srcS + b;
            // Equal input signs and a flipped result sign
            ovf = (op == opAdd) && (srcS[31] == b[31]) && (r[31] != srcS[31]);
        end
        opSub, opSubu: begin
            r = srcS - b;
            ovf = (op == opSub) && (srcS[31] != b[31]) && (r[31] != srcS[31]);
        end
        opSlt:   r = ($signed(srcS) < $signed(b)) ? 32'd1 : 32'd0;
        opSltu:  r = (srcS < b) ? 32'd1 : 32'd0;
        opAnd:   r = srcS & b;
        opOr:    r = srcS | b;
        opXor:   r = srcS ^ b;
        opNor:   r = ~(srcS | b);
        opSll:   r = b << sh;
        opSrl:   r = b >> sh;
        opSra:   r = $signed(b) >>> sh;
        opLui:   r = b;
        default: r = 'x;
    endcase
    return '{value: r, overflow: ovf};
endfunction

`endif

/* dv/aExecTb.sv */
`timescale 1ns/10ps
`default_nettype none
// Self-checking testbench for aExecUnit, random stimulus from a fixed seed
// Inputs change 1 ns after the rising edge; the model samples on the falling edge
// Downstream buffer is modelled only as a count of unreturned results

module aExecTb;
    import aluPkg::*;

    `include "aExecRef.svh"

    // Operations per phase
    localparam int ARITH_OPS        = 400;
    localparam int SET_OPS          = 300;
    localparam int LOGIC_OPS        = 400;
    localparam int SHIFT_OPS        = 300;
    localparam int CREDIT_ROUNDS    = 10;
    localparam int CREDIT_ROUND_OPS = 12;
    localparam int CREDIT_HOLD      = 15;
    localparam int KILL_OPS         = 300;
    localparam int TOTAL_OPS        = ARITH_OPS + SET_OPS + LOGIC_OPS + SHIFT_OPS
                                    + CREDIT_ROUNDS * CREDIT_ROUND_OPS + KILL_OPS;
    // Up to 4 cycles per op, margin for reset, credit holds and drains
    localparam int TIMEOUT_CYCLES   = TOTAL_OPS * 4 + 2720;

    logic                   phi1;
    logic                   rstN;
    logic                   issueValid;
    aluOp_e                 op;
    logic [DATA_WIDTH-1:0]  srcS;
    logic [DATA_WIDTH-1:0]  srcT;
    logic [IMM_WIDTH-1:0]   imm16;
    logic                   useImm;
    logic                   immSigned;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic                   shiftVariable;
    logic                   killEx;
    logic                   creditReturn;
    logic                   stall;
    logic                   resValid;
    logic [DATA_WIDTH-1:0]  result;
    logic                   overflow;

    integer     seed = 32'hd6c0;
    int         mismatchCount = 0;
    int         otherErrCount = 0;
    int         cycleCount = 0;
    // Model state, updated on the falling edge
    int         tbCredits = RESULT_CREDITS;
    int         outstanding = 0;
    logic       inFlight = 1'b0;
    logic       resExpected = 1'b0;
    aluResult_s inFlightExp;
    aluResult_s expQ[$];

    aExecUnit aExecUnit_inst (
        .phi1          (phi1),
        .rstN          (rstN),
        .issueValid    (issueValid),
        .op            (op),
        .srcS          (srcS),
        .srcT          (srcT),
        .imm16         (imm16),
        .useImm        (useImm),
        .immSigned     (immSigned),
        .shamt         (shamt),
        .shiftVariable (shiftVariable),
        .killEx        (killEx),
        .creditReturn  (creditReturn),
        .stall         (stall),
        .resValid      (resValid),
        .result        (result),
        .overflow      (overflow)
    );

    initial begin
        phi1 = 1'b0;
        forever #5 phi1 = ~phi1;
    end

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic bit chance(input int pct);
        return pick(100) < pct;
    endfunction

    // Boundary values for overflow and compare corners
    function automatic logic [DATA_WIDTH-1:0] pickData();
        case (pick(8))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h0000_0001;
            default: return $random(seed);
        endcase
    endfunction

    task automatic checkResult(input aluResult_s got, input aluResult_s exp);
        if (got.value !== exp.value) begin
            mismatchCount++;
            $display("Mismatch at %0t: result got %h expected %h", $time, got.value, exp.value);
        end
        if (got.overflow !== exp.overflow) begin
            mismatchCount++;
            $display("Mismatch at %0t: overflow got %b expected %b",
                     $time, got.overflow, exp.overflow);
        end
    endtask

    task automatic checkStall(input logic got, input logic exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch at %0t: stall got %b expected %b", $time, got, exp);
        end
    endtask

    // New issue; kind picks the op group, 4 means any op
    task automatic driveIssue(input int kind, input bit steady);
        int n;
        issueValid    = steady || chance(85);
        srcS          = pickData();
        srcT          = pickData();
        imm16         = (pick(8) == 0) ? 16'h8000 : 16'($random(seed));
        useImm        = chance(30);
        immSigned     = chance(50);
        shamt         = SHAMT_WIDTH'(pick(32));
        shiftVariable = chance(50);
        case (kind)
            0: op = aluOp_e'(pick(4));
            1: op = aluOp_e'(4 + pick(2));
            2: begin
                n      = pick(5);
                op     = (n == 4) ? opLui : aluOp_e'(6 + n);
                useImm = chance(50);
            end
            3: begin
                op     = aluOp_e'(10 + pick(3));
                useImm = 1'b0;
            end
            default: op = aluOp_e'(pick(14));
        endcase
    endtask

    // Issue numOps operations; credit returns withheld for the first holdCycles
    task automatic runPhase(input int kind, input int numOps, input int killPct,
                            input int holdCycles);
        int issued;
        int cyc;
        int heldResults;
        issued      = 0;
        cyc         = 0;
        heldResults = 0;
        while (issued < numOps) begin
            @(posedge phi1);
            #1;
            cyc++;
            // inFlight here means accepted at the edge just passed
            if (inFlight) begin
                issued++;
            end
            // Results delivered while no credit comes back
            if (cyc <= holdCycles && resValid === 1'b1) begin
                heldResults++;
            end
            if (holdCycles > 0 && cyc == holdCycles && heldResults != RESULT_CREDITS) begin
                otherErrCount++;
                $display("Error at %0t: %0d results with credits withheld, expected %0d",
                         $time, heldResults, RESULT_CREDITS);
            end
            killEx       = inFlight && chance(killPct);
            creditReturn = (cyc > holdCycles) && (outstanding > 0) && chance(75);
            if (issued >= numOps) begin
                issueValid = 1'b0;
            end else if (!issueValid || inFlight) begin
                driveIssue(kind, holdCycles > 0);
            end
        end
    endtask

    // Stop issuing and return every credit
    task automatic drainAll();
        do begin
            @(posedge phi1);
            #1;
            issueValid   = 1'b0;
            killEx       = 1'b0;
            creditReturn = (outstanding > 0);
        end while (tbCredits != RESULT_CREDITS || inFlight || resExpected);
    endtask

    // Model, sampled mid-cycle where inputs and outputs are settled
    always @(negedge phi1) begin
        logic accNow;
        logic keep;
        if (rstN) begin
            checkStall(stall, tbCredits == 0);
            if (resValid !== resExpected) begin
                otherErrCount++;
                $display("Error at %0t: resValid is %b but an issue two cycles back says %b",
                         $time, resValid, resExpected);
            end
            accNow = issueValid && (tbCredits != 0);
            // Kill applies to the op accepted at the last edge
            keep = inFlight && !killEx;
            if (keep) begin
                expQ.push_back(inFlightExp);
            end
            resExpected = keep;
            tbCredits   = tbCredits - int'(accNow) + int'(creditReturn)
                        + int'(inFlight && killEx);
            outstanding = outstanding + int'(resValid) - int'(creditReturn);
            inFlight    = accNow;
            if (accNow) begin
                inFlightExp = refAlu(op, srcS, srcT, imm16, useImm, immSigned,
                                     shamt, shiftVariable);
            end
        end
    end

    // Result compare, outputs read at the edge before they update
    always @(posedge phi1) begin
        aluResult_s got;
        if (rstN && resValid === 1'b1) begin
            got.value    = result;
            got.overflow = overflow;
            if (expQ.size() == 0) begin
                otherErrCount++;
                $display("Error at %0t: resValid with no result outstanding", $time);
            end else begin
                checkResult(got, expQ.pop_front());
            end
        end
    end

    // Run limit
    always @(posedge phi1) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
            $display("Errors: %0d mismatches, %0d other", mismatchCount, otherErrCount);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rstN          = 1'b0;
        issueValid    = 1'b0;
        op            = opAdd;
        srcS          = '0;
        srcT          = '0;
        imm16         = '0;
        useImm        = 1'b0;
        immSigned     = 1'b0;
        shamt         = '0;
        shiftVariable = 1'b0;
        killEx        = 1'b0;
        creditReturn  = 1'b0;
        repeat (8) @(posedge phi1);
        #1;
        rstN = 1'b1;

        runPhase(0, ARITH_OPS, 0, 0);
        runPhase(1, SET_OPS, 0, 0);
        runPhase(2, LOGIC_OPS, 0, 0);
        runPhase(3, SHIFT_OPS, 0, 0);
        // Each round starts with all credits home
        for (int i = 0; i < CREDIT_ROUNDS; i++) begin
            drainAll();
            runPhase(4, CREDIT_ROUND_OPS, 0, CREDIT_HOLD);
        end
        runPhase(4, KILL_OPS, 30, 0);
        drainAll();
        repeat (2) @(posedge phi1);

        if (expQ.size() != 0) begin
            otherErrCount++;
            $display("Error: %0d expected results never came out", expQ.size());
        end
        $display("Errors: %0d mismatches, %0d other", mismatchCount, otherErrCount);
        if (mismatchCount == 0 && otherErrCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/aExecUnit.sv */
`timescale 1ns/10ps
`default_nettype none
// A-side execute unit, two-cycle latency from accepted issue to resValid
// killEx is honoured only in the cycle after an accept
// Results have no back-pressure; downstream space is tracked by credits

module aExecUnit (
    input  logic                           phi1,
    input  logic                           rstN,
    input  logic                           issueValid,
    input  aluPkg::aluOp_e                 op,
    input  logic [aluPkg::DATA_WIDTH-1:0]  srcS,
    input  logic [aluPkg::DATA_WIDTH-1:0]  srcT,
    input  logic [aluPkg::IMM_WIDTH-1:0]   imm16,
    input  logic                           useImm,
    input  logic                           immSigned,
    input  logic [aluPkg::SHAMT_WIDTH-1:0] shamt,
    input  logic                           shiftVariable,
    input  logic                           killEx,
    input  logic                           creditReturn,
    output logic                           stall,
    output logic                           resValid,
    output logic [aluPkg::DATA_WIDTH-1:0]  result,
    output logic                           overflow
);
    import aluPkg::*;

    logic         accept;
    logic         exValid;
    logic         exKill;
    aluOperands_s issueOperands;
    aluOperands_s exOperands;
    aluResult_s   aluOut;
    aluResult_s   resPayload;

    aluControl aluControl_inst (
        .issueValid    (issueValid),
        .op            (op),
        .srcS          (srcS),
        .srcT          (srcT),
        .imm16         (imm16),
        .useImm        (useImm),
        .immSigned     (immSigned),
        .shamt         (shamt),
        .shiftVariable (shiftVariable),
        .stall         (stall),
        .accept        (accept),
        .operands      (issueOperands)
    );

    // Issue to execute, nothing kills here
    pipeStage #(.payload_t(aluOperands_s)) exStage_inst (
        .phi1     (phi1),
        .rstN     (rstN),
        .inValid  (accept),
        .inData   (issueOperands),
        .kill     (1'b0),
        .outValid (exValid),
        .outData  (exOperands)
    );

    aluDatapath aluDatapath_inst (
        .operands (exOperands),
        .result   (aluOut)
    );

    // Execute to result, late kill drops the item here
    pipeStage #(.payload_t(aluResult_s)) resStage_inst (
        .phi1     (phi1),
        .rstN     (rstN),
        .inValid  (exValid),
        .inData   (aluOut),
        .kill     (killEx),
        .outValid (resValid),
        .outData  (resPayload)
    );

    // Kill of a live op frees its slot
    assign exKill = killEx & exValid;

    creditCounter creditCounter_inst (
        .phi1       (phi1),
        .rstN       (rstN),
        .take       (accept),
        .giveReturn (creditReturn),
        .giveKill   (exKill),
        .stall      (stall)
    );

    assign result   = resPayload.value;
    assign overflow = resPayload.overflow;

endmodule

`default_nettype wire

/* source/creditCounter.sv */
`timescale 1ns/10ps
`default_nettype none
// Write buffer credit tracker; stall is a registered-count decode
// Caller must not take at zero and must not give back more than it took

module creditCounter (
    input  logic phi1,
    input  logic rstN,
    input  logic take,
    input  logic giveReturn,
    input  logic giveKill,
    output logic stall
);
    import aluPkg::*;

    logic [CREDIT_WIDTH-1:0] creditCount;
    logic [CREDIT_WIDTH-1:0] countNext;

    // One take and up to two gives may land together
    assign countNext = creditCount - CREDIT_WIDTH'(take)
                     + CREDIT_WIDTH'(giveReturn) + CREDIT_WIDTH'(giveKill);

    always_ff @(posedge phi1 or negedge rstN) begin
        if (!rstN) begin
            creditCount <= CREDIT_WIDTH'(RESULT_CREDITS);
        end else begin
            creditCount <= countNext;
        end
    end

    // No slot left downstream
    assign stall = (creditCount == '0);

    // Downstream or kill path returning a credit twice
    aCreditBound: assert property (
        @(posedge phi1) disable iff (!rstN)
        creditCount <= CREDIT_WIDTH'(RESULT_CREDITS)
    ) else $error("credit count above buffer depth");

    // Issue qualification upstream must honour stall
    aNoTakeEmpty: assert property (
        @(posedge phi1) disable iff (!rstN)
        take |-> (creditCount != '0)
    ) else $error("issue accepted with no credit");

endmodule

`default_nettype wire

/* source/pipeStage.sv */
`timescale 1ns/10ps
`default_nettype none
// One-cycle pipeline register with valid and kill
// Payload holds its value on idle cycles and has no reset

module pipeStage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     phi1,
    input  logic     rstN,
    input  logic     inValid,
    input  payload_t inData,
    input  logic     kill,
    output logic     outValid,
    output payload_t outData
);

    // Valid bit, a killed item never leaves the stage
    always_ff @(posedge phi1 or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid & ~kill;
        end
    end

    // Load only real work, keeps datapath quiet
    always_ff @(posedge phi1) begin
        if (inValid) begin
            outData <= inData;
        end
    end

    // Downstream logic relies on a clean valid
    aValidKnown: assert property (
        @(posedge phi1) disable iff (!rstN)
        !$isunknown(outValid)
    ) else $error("pipeline valid unknown");

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
common/aluPkg.sv
aexec/aluControl.sv
aexec/aluDatapath.sv
source/creditCounter.sv
source/pipeStage.sv
source/aExecUnit.sv
dv/aExecTb.sv
